//--- dcache_subsys.f
+incdir+include
source/dcache_pkg.sv
source/req_port.sv
source/bank_arbiter.sv
source/cache_bank.sv
source/read_return.sv
source/dcache_subsys.sv
test/dcache_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, the verdict comes from the log.

LOG=sim.log

verilator --binary --timing -j 0 --top-module dcache_subsys_tb \
    -f dcache_subsys.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- include/dcache_tb_model.svh
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

// reference copy of the whole array by word address.
dcache_pkg::word_t model_mem [2**ADDR_W];
logic              model_valid [2**ADDR_W]; // word written at least once.
int                error_count;

function automatic void model_clear();
    for (int a = 0; a < 2**ADDR_W; a++) begin
        model_mem[a]   = '0;
        model_valid[a] = 1'b0;
    end
endfunction

// byte n of the word follows mask bit n.
function automatic void model_write(
    input int                 addr,
    input dcache_pkg::word_t  data,
    input dcache_pkg::wmask_t mask
);
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) model_mem[addr][8*i +: 8] = data[8*i +: 8];
    end
    model_valid[addr] = 1'b1;
endfunction

function automatic dcache_pkg::word_t model_read(input int addr);
    return model_mem[addr];
endfunction

// DUT value against its expected value.
task automatic check_value(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
);
    if (got !== exp) begin
        error_count++;
        $display("ERROR: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

`endif

//--- test/dcache_subsys_tb.sv
`timescale 1ns/1ps

module dcache_subsys_tb;

    localparam int ADDR_W    = 8;
    localparam int NUM_TXN   = 300;
    localparam int HOT_WORDS = 32; // small window per client so reads hit earlier writes.
    localparam int RST_CYC   = 16;
    localparam int MAX_CYC   = 2 * NUM_TXN * 12 + RST_CYC;

    logic                  clk;
    logic                  rst;
    logic                  fill_req;
    dcache_pkg::fill_req_t fill_payload;
    logic                  fill_ack;
    dcache_pkg::word_t     fill_rdata;
    logic                  core_req;
    dcache_pkg::core_req_t core_payload;
    logic                  core_ack;
    dcache_pkg::word_t     core_rdata;

    integer seed;
    int     cycle_count;
    int     fill_count;
    int     core_count;
    time    fill_start_t; // edge where each driver raised req.
    time    core_start_t;
    time    fill_acked_t; // start time of the last fill that acked.
    logic   fill_ack_q;
    logic   core_ack_q;

    `include "dcache_tb_model.svh"

    dcache_subsys #(
        .ADDR_W(ADDR_W)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .fill_req    (fill_req),
        .fill_payload(fill_payload),
        .fill_ack    (fill_ack),
        .fill_rdata  (fill_rdata),
        .core_req    (core_req),
        .core_payload(core_payload),
        .core_ack    (core_ack),
        .core_rdata  (core_rdata)
    );

    always #2 clk = ~clk;

    function automatic void note_failure(input string msg);
        error_count++;
        $display("%s at %0t", msg, $time);
    endfunction

    // handshake monitor sampled away from the driving edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (fill_ack && !fill_ack_q) begin
                if (!fill_req) note_failure("fill ack rose while fill req was low");
                fill_acked_t = fill_start_t;
            end
            if (core_ack && !core_ack_q) begin
                if (!core_req) note_failure("core ack rose while core req was low");
                if (core_start_t == fill_start_t && fill_acked_t != fill_start_t) begin
                    note_failure("core acked before fill although both were raised together");
                end
            end
        end
        fill_ack_q = fill_ack;
        core_ack_q = core_ack;
    end

    // fill client with full words in the upper half of the address space.
    task automatic run_fill();
        dcache_pkg::fill_req_t p;
        logic [31:0] r;
        int addr;
        int gap;
        int lat;
        int drop;
        bit alone;
        for (int n = 0; n < NUM_TXN; n++) begin
            r    = $random(seed);
            gap  = int'(r % 4);
            addr = (1 << (ADDR_W - 1)) + int'((r >> 4) % HOT_WORDS);
            p.we    = r[12] || !model_valid[addr]; // never read an unwritten word.
            p.addr  = 16'(addr);
            p.wdata = $random(seed);
            repeat (gap + 1) @(posedge clk);
            fill_req     <= 1'b1;
            fill_payload <= p;
            fill_start_t = $time;
            lat   = 0;
            alone = 1'b1;
            @(negedge clk);
            if (core_req) alone = 1'b0;
            while (!fill_ack) begin
                @(negedge clk);
                lat++;
                if (core_req) alone = 1'b0;
            end
            if (alone) check_value("fill_ack latency", 32'(lat), 32'd3);
            if (p.we) model_write(addr, p.wdata, 4'hf);
            else check_value("fill_rdata", fill_rdata, model_read(addr));
            @(posedge clk);
            fill_req <= 1'b0;
            drop = 0;
            do begin
                @(negedge clk);
                drop++;
            end while (fill_ack && drop < 3);
            if (fill_ack) note_failure("fill ack stayed high after fill req dropped");
            fill_count++;
        end
    endtask

    // core client with masked accesses in the lower half.
    task automatic run_core();
        dcache_pkg::core_req_t p;
        logic [31:0] r;
        int addr;
        int gap;
        int lat;
        int drop;
        bit alone;
        for (int n = 0; n < NUM_TXN; n++) begin
            r    = $random(seed);
            gap  = int'(r % 4);
            addr = int'((r >> 4) % HOT_WORDS);
            p.we    = r[12] || !model_valid[addr];
            p.wmask = model_valid[addr] ? r[19:16] : 4'hf; // first write fills the word.
            p.addr  = 16'(addr);
            p.wdata = $random(seed);
            repeat (gap + 1) @(posedge clk);
            core_req     <= 1'b1;
            core_payload <= p;
            core_start_t = $time;
            lat   = 0;
            alone = 1'b1;
            @(negedge clk);
            if (fill_req) alone = 1'b0;
            while (!core_ack) begin
                @(negedge clk);
                lat++;
                if (fill_req) alone = 1'b0;
            end
            if (alone) check_value("core_ack latency", 32'(lat), 32'd3);
            if (p.we) model_write(addr, p.wdata, p.wmask);
            else check_value("core_rdata", core_rdata, model_read(addr));
            @(posedge clk);
            core_req <= 1'b0;
            drop = 0;
            do begin
                @(negedge clk);
                drop++;
            end while (core_ack && drop < 3);
            if (core_ack) note_failure("core ack stayed high after core req dropped");
            core_count++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fill_req     = 1'b0;
        fill_payload = '0;
        core_req     = 1'b0;
        core_payload = '0;
        seed         = 27880;
        error_count  = 0;
        fill_count   = 0;
        core_count   = 0;
        fill_start_t = 0;
        core_start_t = 0;
        fill_acked_t = 0;
        fill_ack_q   = 1'b0;
        core_ack_q   = 1'b0;
        model_clear();
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        // both acks stay low while idle after reset.
        repeat (4) begin
            @(negedge clk);
            check_value("fill_ack", {31'b0, fill_ack}, 32'h0);
            check_value("core_ack", {31'b0, core_ack}, 32'h0);
        end
        fork
            run_fill();
            run_core();
        join
        repeat (2) @(posedge clk);
        $display("fill txns %0d, core txns %0d, errors %0d", fill_count, core_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run limit from the transaction count.
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYC) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the drivers did not finish within %0d cycles", MAX_CYC);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/dcache_subsys.sv
`timescale 1ns/1ps

module dcache_subsys #(
    parameter int ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // memory controller fill/writeback port.
    input  logic                  fill_req,
    input  dcache_pkg::fill_req_t fill_payload,
    output logic                  fill_ack,
    output dcache_pkg::word_t     fill_rdata,

    // core load/store port.
    input  logic                  core_req,
    input  dcache_pkg::core_req_t core_payload,
    output logic                  core_ack,
    output dcache_pkg::word_t     core_rdata
);

    logic                  fill_pending;
    logic                  core_pending;
    dcache_pkg::fill_req_t fill_held;
    dcache_pkg::core_req_t core_held;
    logic                  fill_done;
    logic                  core_done;
    dcache_pkg::bank_req_t bank0_access;
    dcache_pkg::bank_req_t bank1_access;
    dcache_pkg::word_t     bank0_rdata;
    dcache_pkg::word_t     bank1_rdata;
    logic                  fill_valid;
    logic                  core_valid;
    dcache_pkg::word_t     fill_word;
    dcache_pkg::word_t     core_word;

    dcache_pkg::owner_t [dcache_pkg::NUM_BANKS-1:0] owner_q;

    req_port #(
        .PAYLOAD_T(dcache_pkg::fill_req_t)
    ) fill_port (
        .clk      (clk),
        .rst      (rst),
        .req      (fill_req),
        .payload  (fill_payload),
        .ack      (fill_ack),
        .rdata    (fill_rdata),
        .pending  (fill_pending),
        .held     (fill_held),
        .done     (fill_done),
        .ret_valid(fill_valid),
        .ret_word (fill_word)
    );

    req_port #(
        .PAYLOAD_T(dcache_pkg::core_req_t)
    ) core_port (
        .clk      (clk),
        .rst      (rst),
        .req      (core_req),
        .payload  (core_payload),
        .ack      (core_ack),
        .rdata    (core_rdata),
        .pending  (core_pending),
        .held     (core_held),
        .done     (core_done),
        .ret_valid(core_valid),
        .ret_word (core_word)
    );

    bank_arbiter #(
        .ADDR_W(ADDR_W)
    ) arbiter (
        .clk         (clk),
        .rst         (rst),
        .fill_pending(fill_pending),
        .fill_held   (fill_held),
        .core_pending(core_pending),
        .core_held   (core_held),
        .fill_done   (fill_done),
        .core_done   (core_done),
        .bank0       (bank0_access),
        .bank1       (bank1_access),
        .owner_q     (owner_q)
    );

    cache_bank #(
        .ADDR_W(ADDR_W)
    ) bank0 (
        .clk   (clk),
        .access(bank0_access),
        .rdata (bank0_rdata)
    );

    cache_bank #(
        .ADDR_W(ADDR_W)
    ) bank1 (
        .clk   (clk),
        .access(bank1_access),
        .rdata (bank1_rdata)
    );

    read_return ret (
        .bank0_rdata(bank0_rdata),
        .bank1_rdata(bank1_rdata),
        .owner_q    (owner_q),
        .fill_valid (fill_valid),
        .fill_word  (fill_word),
        .core_valid (core_valid),
        .core_word  (core_word)
    );

endmodule

//--- source/read_return.sv
`timescale 1ns/1ps

module read_return (
    input  dcache_pkg::word_t                             bank0_rdata,
    input  dcache_pkg::word_t                             bank1_rdata,
    input  dcache_pkg::owner_t [dcache_pkg::NUM_BANKS-1:0] owner_q,
    output logic                                          fill_valid,
    output dcache_pkg::word_t                             fill_word,
    output logic                                          core_valid,
    output dcache_pkg::word_t                             core_word
);

    dcache_pkg::word_t bank_rdata [dcache_pkg::NUM_BANKS];

    assign bank_rdata[0] = bank0_rdata;
    assign bank_rdata[1] = bank1_rdata;

    // each client reads at most one bank per cycle.
    always_comb begin
        fill_valid = 1'b0;
        fill_word  = '0;
        core_valid = 1'b0;
        core_word  = '0;
        for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
            if (owner_q[b].rd) begin
                if (owner_q[b].client == dcache_pkg::CLIENT_FILL) begin
                    fill_valid = 1'b1;
                    fill_word  = bank_rdata[b];
                end else begin
                    core_valid = 1'b1;
                    core_word  = bank_rdata[b];
                end
            end
        end
    end

endmodule

//--- source/cache_bank.sv
`timescale 1ns/1ps

module cache_bank #(
    parameter int ADDR_W = 8
) (
    input  logic                  clk,
    input  dcache_pkg::bank_req_t access,
    output dcache_pkg::word_t     rdata
);

    localparam int DEPTH = 2 ** (ADDR_W - 1);

    dcache_pkg::word_t mem [DEPTH];

    logic [ADDR_W-2:0] idx;

    assign idx = access.addr[ADDR_W-2:0]; // bank index with bit 0 already stripped.

    always_ff @(posedge clk) begin
        if (access.ce) begin
            if (access.we) begin
                // only enabled bytes change.
                for (int i = 0; i < 4; i++) begin
                    if (access.wmask[i]) begin
                        mem[idx][8*i +: 8] <= access.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx]; // ready one edge later.
            end
        end
    end

endmodule

//--- source/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          fill_pending,
    input  dcache_pkg::fill_req_t                         fill_held,
    input  logic                                          core_pending,
    input  dcache_pkg::core_req_t                         core_held,
    output logic                                          fill_done,
    output logic                                          core_done,
    output dcache_pkg::bank_req_t                         bank0,
    output dcache_pkg::bank_req_t                         bank1,
    output dcache_pkg::owner_t [dcache_pkg::NUM_BANKS-1:0] owner_q
);

    dcache_pkg::bank_req_t fill_norm;
    dcache_pkg::bank_req_t core_norm;
    dcache_pkg::bank_req_t bank_sel [dcache_pkg::NUM_BANKS];
    dcache_pkg::client_e   bank_owner [dcache_pkg::NUM_BANKS];

    logic fill_bank;
    logic core_bank;
    logic conflict;

    // normalize both clients to the bank access format.
    always_comb begin
        fill_norm.ce    = fill_pending;
        fill_norm.we    = fill_held.we;
        fill_norm.wmask = '1; // fill always writes the whole word.
        fill_norm.addr  = dcache_pkg::addr_t'(fill_held.addr[ADDR_W-1:1]);
        fill_norm.wdata = fill_held.wdata;

        core_norm.ce    = core_pending;
        core_norm.we    = core_held.we;
        core_norm.wmask = core_held.wmask;
        core_norm.addr  = dcache_pkg::addr_t'(core_held.addr[ADDR_W-1:1]);
        core_norm.wdata = core_held.wdata;
    end

    assign fill_bank = fill_held.addr[0];
    assign core_bank = core_held.addr[0];

    // core waits when both want the same bank.
    assign conflict  = fill_pending && core_pending && (fill_bank == core_bank);

    assign fill_done = fill_pending;
    assign core_done = core_pending && !conflict;

    always_comb begin
        for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
            bank_sel[b]   = '0;
            bank_owner[b] = dcache_pkg::CLIENT_FILL;
            if (fill_pending && fill_bank == 1'(b)) begin
                bank_sel[b]   = fill_norm;
                bank_owner[b] = dcache_pkg::CLIENT_FILL;
            end else if (core_pending && core_bank == 1'(b)) begin
                bank_sel[b]   = core_norm;
                bank_owner[b] = dcache_pkg::CLIENT_CORE;
            end
        end
    end

    assign bank0 = bank_sel[0];
    assign bank1 = bank_sel[1];

    // remember the reader of each bank for the return stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= '0;
        end else begin
            for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                owner_q[b].rd     <= bank_sel[b].ce && !bank_sel[b].we;
                owner_q[b].client <= bank_owner[b];
            end
        end
    end

endmodule

//--- source/req_port.sv
`timescale 1ns/1ps

module req_port #(
    parameter type PAYLOAD_T = dcache_pkg::core_req_t
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  PAYLOAD_T          payload,
    output logic              ack,
    output dcache_pkg::word_t rdata,
    output logic              pending,
    output PAYLOAD_T          held,
    input  logic              done,
    input  logic              ret_valid,
    input  dcache_pkg::word_t ret_word
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PEND,
        S_DATA,
        S_ACK,
        S_WAIT_LOW
    } state_e;

    state_e state;

    assign pending = (state == S_PEND);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_PEND;
                    end
                end
                S_PEND: begin
                    if (done) state <= S_DATA; // granted this cycle.
                end
                S_DATA: begin
                    // bank output is valid now for a read.
                    if (held.we || ret_valid) begin
                        state <= S_ACK;
                        ack   <= 1'b1;
                    end
                end
                S_ACK: begin
                    if (!req) begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end else begin
                        state <= S_WAIT_LOW;
                    end
                end
                S_WAIT_LOW: begin
                    if (!req) begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // captured payload and returned read word.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) held <= payload;
        if (state == S_DATA && !held.we && ret_valid) rdata <= ret_word;
    end

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

    // data path is fixed at one 32-bit word.
    typedef logic [31:0] word_t;

    // bit n enables byte n of the word.
    typedef logic [3:0] wmask_t;

    // word address of which only the low ADDR_W bits are live.
    typedef logic [15:0] addr_t;

    // two banks interleaved on address bit 0.
    localparam int NUM_BANKS = 2;

    // memory controller request with full-word writes.
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } fill_req_t;

    // core load/store side.
    typedef struct packed {
        logic   we;
        wmask_t wmask;
        addr_t  addr;
        word_t  wdata;
    } core_req_t;

    // one bank access with addr as the index inside the bank.
    typedef struct packed {
        logic   ce;
        logic   we;
        wmask_t wmask;
        addr_t  addr;
        word_t  wdata;
    } bank_req_t;

    typedef enum logic {
        CLIENT_FILL = 1'b0,
        CLIENT_CORE = 1'b1
    } client_e;

    // who read a bank in the previous cycle.
    typedef struct packed {
        logic    rd;
        client_e client;
    } owner_t;

endpackage
